//--- rtl/core_cfg_pkg.sv
/*
 * core configuration for the RV32I integer core
 * data and register index widths, ALU operation encoding
 */

package core_cfg_pkg;

    localparam int XLEN       = 32;
    localparam int REG_COUNT  = 32;
    localparam int REG_ADDR_W = 5;

    // operations the execute stage knows about
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10   // LUI
    } alu_op_e;

endpackage

//--- rtl/rv_isa_pkg.sv
/*
 * RV32I encodings used by the integer core
 * opcodes, funct3/funct7 codes and the instruction word views
 */

package rv_isa_pkg;

    // major opcodes
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;  // srl / sra
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub, sra

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_s;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_s;

    // one word, two views
    typedef union packed {
        r_fmt_s r;
        i_fmt_s i;
    } inst_u;

endpackage

//--- rtl/dec_exe_if.sv
/*
 * decode to execute link
 * carries one decoded operation with its operands
 */

`timescale 1ns/10ps

interface dec_exe_if import core_cfg_pkg::*; ();

    logic                  valid;      // one cycle pulse
    alu_op_e               op;
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       operand_b;
    logic [REG_ADDR_W-1:0] rd;
    logic                  rd_we;

    modport decode (
        output valid, op, operand_a, operand_b, rd, rd_we
    );

    modport execute (
        input valid, op, operand_a, operand_b, rd, rd_we
    );

endinterface

//--- rtl/exe_res_if.sv
/*
 * execute to write-back link
 * carries the ALU result and its destination
 */

`timescale 1ns/10ps

interface exe_res_if import core_cfg_pkg::*; ();

    logic                  valid;
    logic [XLEN-1:0]       result;
    logic [REG_ADDR_W-1:0] rd;
    logic                  rd_we;

    modport execute (
        output valid, result, rd, rd_we
    );

    modport writeback (
        input valid, result, rd, rd_we
    );

endinterface

//--- rtl/inst_decode.sv
/*
 * instruction decode
 * takes one request, decodes it, reads operands and forms the immediate
 */

`timescale 1ns/10ps

module inst_decode import core_cfg_pkg::*, rv_isa_pkg::*; (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic [XLEN-1:0]       inst_i,
    input  logic                  inst_req_i,
    input  logic [XLEN-1:0]       rs1_data_i,
    input  logic [XLEN-1:0]       rs2_data_i,
    output logic [REG_ADDR_W-1:0] rs1_addr_o,
    output logic [REG_ADDR_W-1:0] rs2_addr_o,
    dec_exe_if.decode             dec_o
);

    inst_u           inst;
    logic            taken;   // request already accepted
    logic            accept;
    alu_op_e         op_d;
    logic [XLEN-1:0] opb_d;
    logic            we_d;

    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt,
                                        input logic reg_form);
        case (f3)
            F3_ADD_SUB: return (alt && reg_form) ? ALU_SUB : ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SR:      return alt ? ALU_SRA : ALU_SRL;
            F3_OR:      return ALU_OR;
            F3_AND:     return ALU_AND;
            default:    return ALU_ADD;
        endcase
    endfunction

    assign inst       = inst_i;
    assign rs1_addr_o = inst.r.rs1;
    assign rs2_addr_o = inst.r.rs2;
    assign accept     = inst_req_i && !taken;

    always_comb begin
        op_d  = ALU_ADD;
        opb_d = '0;
        we_d  = 1'b0;   // unknown opcode writes nothing
        case (inst.r.opcode)
            OPC_OP: begin
                opb_d = rs2_data_i;
                we_d  = (inst.r.funct7 == F7_BASE) || (inst.r.funct7 == F7_ALT);
                op_d  = alu_sel(inst.r.funct3, inst_i[30], 1'b1);
            end
            OPC_OP_IMM: begin
                opb_d = {{(XLEN-12){inst.i.imm12[11]}}, inst.i.imm12};
                we_d  = 1'b1;
                if ((inst.i.funct3 == F3_SLL) || (inst.i.funct3 == F3_SR)) begin
                    // upper bits of the shamt form act as funct7
                    opb_d = {{(XLEN-5){1'b0}}, inst.i.imm12[4:0]};
                    we_d  = (inst.i.imm12[11:5] == F7_BASE) || (inst.i.imm12[11:5] == F7_ALT);
                end
                op_d = alu_sel(inst.i.funct3, inst_i[30], 1'b0);
            end
            OPC_LUI: begin
                opb_d = {inst_i[31:12], {12{1'b0}}};
                we_d  = 1'b1;
                op_d  = ALU_PASS_B;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            taken       <= 1'b0;
            dec_o.valid <= 1'b0;
        end else begin
            dec_o.valid <= accept;
            if (accept) begin
                taken <= 1'b1;
            end else if (!inst_req_i) begin
                taken <= 1'b0;   // ready for the next request
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec_o.op        <= op_d;
            dec_o.operand_a <= rs1_data_i;
            dec_o.operand_b <= opb_d;
            dec_o.rd        <= inst.r.rd;
            dec_o.rd_we     <= we_d;
        end
    end

endmodule

//--- rtl/alu_execute.sv
/*
 * execute stage
 * registered ALU for the kept RV32I integer operations
 */

`timescale 1ns/10ps

module alu_execute import core_cfg_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    dec_exe_if.execute dec_i,
    exe_res_if.execute res_o
);

    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [4:0]      shamt;
    logic [XLEN-1:0] alu_out;

    assign a     = dec_i.operand_a;
    assign b     = dec_i.operand_b;
    assign shamt = b[4:0];

    always_comb begin
        case (dec_i.op)
            ALU_ADD:    alu_out = a + b;
            ALU_SUB:    alu_out = a - b;
            ALU_SLL:    alu_out = a << shamt;
            ALU_SLT:    alu_out = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU:   alu_out = {{(XLEN-1){1'b0}}, a < b};
            ALU_XOR:    alu_out = a ^ b;
            ALU_SRL:    alu_out = a >> shamt;
            ALU_SRA:    alu_out = $signed(a) >>> shamt;   // keeps sign
            ALU_OR:     alu_out = a | b;
            ALU_AND:    alu_out = a & b;
            ALU_PASS_B: alu_out = b;
            default:    alu_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            res_o.valid <= 1'b0;
        end else begin
            res_o.valid <= dec_i.valid;
        end
    end

    // result record follows the valid pulse
    always_ff @(posedge clk) begin
        if (dec_i.valid) begin
            res_o.result <= alu_out;
            res_o.rd     <= dec_i.rd;
            res_o.rd_we  <= dec_i.rd_we;
        end
    end

endmodule

//--- rtl/result_writeback.sv
/*
 * write-back stage
 * commits the result to the register file and closes the handshake
 */

`timescale 1ns/10ps

module result_writeback import core_cfg_pkg::*; (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  inst_req_i,
    exe_res_if.writeback          res_i,
    output logic                  rf_we_o,
    output logic [REG_ADDR_W-1:0] rf_waddr_o,
    output logic [XLEN-1:0]       rf_wdata_o,
    output logic                  inst_ack_o,
    output logic                  wb_we_o,
    output logic [REG_ADDR_W-1:0] wb_addr_o,
    output logic [XLEN-1:0]       wb_data_o
);

    logic commit;

    // x0 is never written
    assign commit     = res_i.valid && res_i.rd_we && (res_i.rd != '0);
    assign rf_we_o    = commit;
    assign rf_waddr_o = res_i.rd;
    assign rf_wdata_o = res_i.result;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            inst_ack_o <= 1'b0;
            wb_we_o    <= 1'b0;
        end else if (res_i.valid) begin
            inst_ack_o <= 1'b1;
            wb_we_o    <= commit;
        end else if (!inst_req_i) begin
            inst_ack_o <= 1'b0;   // source let go of the request
            wb_we_o    <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (res_i.valid) begin
            wb_addr_o <= res_i.rd;
            wb_data_o <= res_i.result;
        end
    end

endmodule

//--- rtl/reg_file.sv
/*
 * integer register file
 * two combinational reads, one synchronous write, x0 reads zero
 */

`timescale 1ns/10ps

module reg_file import core_cfg_pkg::*; (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic [REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [REG_ADDR_W-1:0] rs2_addr_i,
    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] waddr_i,
    input  logic [XLEN-1:0]       wdata_i,
    output logic [XLEN-1:0]       rs1_data_o,
    output logic [XLEN-1:0]       rs2_data_o
);

    logic [XLEN-1:0] regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

//--- rtl/rv_alu_core.sv
/*
 * RV32I integer core, top level
 * decode, execute, write-back and the register file
 */

`timescale 1ns/10ps

module rv_alu_core import core_cfg_pkg::*; (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic [XLEN-1:0]       inst_i,
    input  logic                  inst_req_i,
    output logic                  inst_ack_o,
    output logic                  wb_we_o,
    output logic [REG_ADDR_W-1:0] wb_addr_o,
    output logic [XLEN-1:0]       wb_data_o
);

    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [XLEN-1:0]       rf_wdata;

    dec_exe_if dec_exe ();
    exe_res_if exe_res ();

    inst_decode inst_decode_inst (
        .clk        (clk),
        .reset_i    (reset_i),
        .inst_i     (inst_i),
        .inst_req_i (inst_req_i),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .dec_o      (dec_exe.decode)
    );

    alu_execute alu_execute_inst (
        .clk     (clk),
        .reset_i (reset_i),
        .dec_i   (dec_exe.execute),
        .res_o   (exe_res.execute)
    );

    result_writeback result_writeback_inst (
        .clk        (clk),
        .reset_i    (reset_i),
        .inst_req_i (inst_req_i),
        .res_i      (exe_res.writeback),
        .rf_we_o    (rf_we),
        .rf_waddr_o (rf_waddr),
        .rf_wdata_o (rf_wdata),
        .inst_ack_o (inst_ack_o),
        .wb_we_o    (wb_we_o),
        .wb_addr_o  (wb_addr_o),
        .wb_data_o  (wb_data_o)
    );

    reg_file reg_file_inst (
        .clk        (clk),
        .reset_i    (reset_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .we_i       (rf_we),
        .waddr_i    (rf_waddr),
        .wdata_i    (rf_wdata),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

endmodule

//--- tb/tb_clock_gen.sv
/*
 * testbench clock and reset source
 * free running clock, reset held high for a number of cycles
 */

`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 10,
    parameter int RELEASE_DLY  = 2
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #(RELEASE_DLY) reset_o = 1'b0;   // same offset as the other inputs
    end

endmodule

//--- tb/tb_rv_alu_core.sv
/*
 * testbench for the RV32I integer core
 * four-phase handshake driver, reference model and write-back checker
 */

`timescale 1ns/10ps

module tb_rv_alu_core import rv_isa_pkg::*; ();

    localparam int CLK_PERIOD_NS = 40;
    localparam int RESET_CYCLES  = 10;
    localparam int DRIVE_DLY     = 2;
    localparam int N_IMM_RAND    = 64;
    localparam int N_REG_RAND    = 64;
    // reset reads, constants, directed imm, directed reg, x0, illegal
    localparam int N_TOTAL     = 32 + 10 + 8 + N_IMM_RAND + 12 + N_REG_RAND + 4 + 7;
    localparam int WATCHDOG_NS = (N_TOTAL * 20 + RESET_CYCLES) * CLK_PERIOD_NS;

    logic        clk;
    logic        reset_i;
    logic [31:0] inst_i;
    logic        inst_req_i;
    logic        inst_ack_o;
    logic        wb_we_o;
    logic [4:0]  wb_addr_o;
    logic [31:0] wb_data_o;

    logic [31:0] model_regs [32];
    logic [31:0] lcg_state;
    logic        exp_we;
    logic [4:0]  exp_addr;
    logic [31:0] exp_data;
    logic [31:0] last_wb_data;
    int          n_done;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(RESET_CYCLES),
                   .RELEASE_DLY(DRIVE_DLY)) clock_gen_inst (
        .clk_o   (clk),
        .reset_o (reset_i)
    );

    rv_alu_core rv_alu_core_inst (
        .clk        (clk),
        .reset_i    (reset_i),
        .inst_i     (inst_i),
        .inst_req_i (inst_req_i),
        .inst_ack_o (inst_ack_o),
        .wb_we_o    (wb_we_o),
        .wb_addr_o  (wb_addr_o),
        .wb_data_o  (wb_data_o)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] model_read(input logic [4:0] idx);
        return (idx == 5'd0) ? 32'h0 : model_regs[idx];
    endfunction

    // expected write-back of one instruction against the model registers
    function automatic void ref_exec(input logic [31:0] ins, output logic we,
                                     output logic [31:0] data);
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        logic        alt;
        a    = model_read(ins[19:15]);
        alt  = ins[30];
        we   = 1'b1;
        data = 32'h0;
        if (ins[6:0] == OPC_OP) begin
            b  = model_read(ins[24:20]);
            we = (ins[31:25] == F7_BASE) || (ins[31:25] == F7_ALT);
        end else begin
            b   = {{20{ins[31]}}, ins[31:20]};
            alt = alt && (ins[14:12] == F3_SR);   // addi has no subtract form
            if (ins[14:12] == F3_SLL || ins[14:12] == F3_SR)
                we = (ins[31:25] == F7_BASE) || (ins[31:25] == F7_ALT);
        end
        sh = b[4:0];
        case (ins[14:12])
            F3_ADD_SUB: data = alt ? a - b : a + b;
            F3_SLL:     data = a << sh;
            F3_SLT:     data = (a[31] != b[31]) ? {31'h0, a[31]} : {31'h0, a < b};
            F3_SLTU:    data = {31'h0, a < b};
            F3_XOR:     data = a ^ b;
            F3_SR:      data = (a >> sh) | ((alt && a[31]) ? ~(32'hffffffff >> sh) : 32'h0);
            F3_OR:      data = a | b;
            default:    data = a & b;
        endcase
        if (ins[6:0] == OPC_LUI) begin
            data = {ins[31:12], 12'h0};
            we   = 1'b1;   // upper immediate has no funct fields
        end else if (ins[6:0] != OPC_OP && ins[6:0] != OPC_OP_IMM) begin
            we = 1'b0;
        end
        if (ins[11:7] == 5'd0)
            we = 1'b0;
    endfunction

    // one full four-phase handshake starting at edge plus drive delay
    task automatic run_instr(input logic [31:0] ins);
        logic        we;
        logic [31:0] data;
        logic [31:0] r;
        ref_exec(ins, we, data);
        exp_we   = we;
        exp_addr = ins[11:7];
        exp_data = data;
        assert (inst_ack_o === 1'b0) else
            report_failure("acknowledge was still high when a new request started");
        inst_i = ins;
        @(posedge clk);
        #DRIVE_DLY;
        inst_req_i = 1'b1;
        while (inst_ack_o !== 1'b1) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        if (we)
            model_regs[ins[11:7]] = data;
        last_wb_data = wb_data_o;
        r = next_rand();
        repeat (r[25:24]) begin   // source holds the request a while
            @(posedge clk);
            #DRIVE_DLY;
            assert (inst_ack_o === 1'b1) else
                report_failure("acknowledge dropped while the request was still high");
        end
        inst_req_i = 1'b0;
        while (inst_ack_o !== 1'b0) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        n_done++;
    endtask

    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800;   // compensates the sign of the low part
        run_instr({upper[31:12], rd, OPC_LUI});
        run_instr(enc_i(value[11:0], rd, F3_ADD_SUB, rd));
        assert (last_wb_data === value) else
            report_failure($sformatf("CHECK FAILED: wb_data_o = %h, expected %h",
                                     last_wb_data, value));
    endtask

    always @(negedge clk) begin
        if (reset_i === 1'b0 && inst_ack_o === 1'b1) begin
            assert (wb_we_o === exp_we) else
                report_failure($sformatf("CHECK FAILED: wb_we_o = %h, expected %h",
                                         wb_we_o, exp_we));
            if (exp_we) begin
                assert (wb_addr_o === exp_addr) else
                    report_failure($sformatf("CHECK FAILED: wb_addr_o = %h, expected %h",
                                             wb_addr_o, exp_addr));
                assert (wb_data_o === exp_data) else
                    report_failure($sformatf("CHECK FAILED: wb_data_o = %h, expected %h",
                                             wb_data_o, exp_data));
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        report_failure($sformatf("handshake hung, only %0d of %0d instructions completed",
                                 n_done, N_TOTAL));
    end

    initial begin
        logic [31:0] r;
        logic [31:0] r2;
        logic [11:0] imm;
        logic [4:0]  rd;
        logic [4:0]  prev_rd;
        logic [2:0]  f3;
        inst_i     = 32'h0;
        inst_req_i = 1'b0;
        exp_we     = 1'b0;
        exp_addr   = 5'd0;
        exp_data   = 32'h0;
        lcg_state  = 32'hf657;
        n_done     = 0;
        for (int i = 0; i < 32; i++)
            model_regs[i] = 32'h0;
        wait (reset_i === 1'b0);
        @(posedge clk);
        #DRIVE_DLY;
        assert (inst_ack_o === 1'b0) else
            report_failure($sformatf("CHECK FAILED: inst_ack_o = %h, expected 0", inst_ack_o));
        assert (wb_we_o === 1'b0) else
            report_failure($sformatf("CHECK FAILED: wb_we_o = %h, expected 0", wb_we_o));
        for (int i = 0; i < 32; i++)
            run_instr(enc_i(12'h000, 5'(i), F3_ADD_SUB, 5'(i)));

        load_const(5'd1, 32'hdeadbeef);
        load_const(5'd2, 32'h12345678);
        load_const(5'd3, 32'h80000000);
        load_const(5'd4, 32'h7fffffff);
        load_const(5'd5, 32'hfffff800);

        // signed edges for the compares and shifts
        run_instr(enc_i(12'hfff, 5'd3, F3_SLT, 5'd11));
        run_instr(enc_i(12'h800, 5'd4, F3_SLT, 5'd12));
        run_instr(enc_i(12'h7ff, 5'd4, F3_SLT, 5'd18));
        run_instr(enc_i(12'hfff, 5'd3, F3_SLTU, 5'd13));
        run_instr(enc_i(12'h001, 5'd0, F3_SLTU, 5'd14));
        run_instr(enc_i({F7_ALT, 5'd31}, 5'd3, F3_SR, 5'd15));
        run_instr(enc_i({F7_BASE, 5'd31}, 5'd3, F3_SR, 5'd16));
        run_instr(enc_i({F7_BASE, 5'd1}, 5'd4, F3_SLL, 5'd17));

        for (int n = 0; n < N_IMM_RAND; n++) begin
            r   = next_rand();
            r2  = next_rand();
            rd  = (r[23:19] == 5'd0) ? 5'd1 : r[23:19];
            f3  = r[31:29];
            imm = r2[31:20];
            if (f3 == F3_SLL || f3 == F3_SR)
                imm[11:5] = (f3 == F3_SR && r2[19]) ? F7_ALT : F7_BASE;
            if (n % 4 == 0)
                run_instr({r2[31:12], rd, OPC_LUI});   // fresh upper bits
            else
                run_instr(enc_i(imm, r[28:24], f3, rd));
        end

        load_const(5'd21, 32'h80000f0f);
        run_instr(enc_i(12'hff9, 5'd0, F3_ADD_SUB, 5'd22));
        run_instr(enc_i(12'h003, 5'd0, F3_ADD_SUB, 5'd23));
        run_instr(enc_r(F7_ALT, 5'd22, 5'd23, F3_ADD_SUB, 5'd24));
        run_instr(enc_r(F7_ALT, 5'd23, 5'd22, F3_ADD_SUB, 5'd25));
        run_instr(enc_r(F7_ALT, 5'd23, 5'd21, F3_SR, 5'd26));
        run_instr(enc_r(F7_ALT, 5'd23, 5'd22, F3_SR, 5'd27));
        run_instr(enc_r(F7_BASE, 5'd23, 5'd22, F3_SLT, 5'd28));
        run_instr(enc_r(F7_BASE, 5'd23, 5'd22, F3_SLTU, 5'd29));
        run_instr(enc_r(F7_BASE, 5'd22, 5'd21, F3_SLT, 5'd30));
        run_instr(enc_r(F7_BASE, 5'd21, 5'd23, F3_SLTU, 5'd31));

        prev_rd = 5'd24;
        for (int n = 0; n < N_REG_RAND; n++) begin
            r  = next_rand();
            rd = (r[23:19] == 5'd0) ? 5'd2 : r[23:19];
            f3 = r[31:29];
            // rs1 is the previous destination
            run_instr(enc_r(((f3 == F3_ADD_SUB || f3 == F3_SR) && r[18]) ? F7_ALT : F7_BASE,
                            r[28:24], prev_rd, f3, rd));
            prev_rd = rd;
        end

        run_instr(enc_i(12'h005, 5'd1, F3_ADD_SUB, 5'd0));
        run_instr(enc_r(F7_BASE, 5'd2, 5'd1, F3_ADD_SUB, 5'd0));
        run_instr({20'habcde, 5'd0, OPC_LUI});
        run_instr(enc_i(12'h000, 5'd0, F3_ADD_SUB, 5'd8));   // x0 still zero

        run_instr(enc_i(12'h123, 5'd0, F3_ADD_SUB, 5'd9));
        run_instr({20'h12345, 5'd9, 7'b1111111});
        run_instr({20'h00000, 5'd9, 7'b0000011});
        run_instr(enc_r(7'b0000001, 5'd2, 5'd1, F3_ADD_SUB, 5'd9));
        run_instr(enc_r(7'b1000000, 5'd2, 5'd1, F3_XOR, 5'd9));
        run_instr(enc_i({7'b0110000, 5'd3}, 5'd1, F3_SR, 5'd9));
        run_instr(enc_i(12'h000, 5'd9, F3_ADD_SUB, 5'd10));   // x9 untouched

        $display("%0d instructions completed", n_done);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- verilog.f
rtl/core_cfg_pkg.sv
rtl/rv_isa_pkg.sv
rtl/dec_exe_if.sv
rtl/exe_res_if.sv
rtl/inst_decode.sv
rtl/alu_execute.sv
rtl/result_writeback.sv
rtl/reg_file.sv
rtl/rv_alu_core.sv
tb/tb_clock_gen.sv
tb/tb_rv_alu_core.sv

//--- run.sh
#!/bin/sh
# build the RV32I core testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_alu_core \
    -f verilog.f > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vtb_rv_alu_core > sim.log 2>&1
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1
grep -q "TESTS PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
